// File: hdl/skin_pkg.sv
// Shared widths, payload structs and colour thresholds for the skin segmenter.
// Every design file refers to these by scoped name.
package skin_pkg;

    // Pixel address, enough for a 320x240 frame
    localparam int ADDR_W = 17;

    // Channel sum over a full frame, 255 * 76800 fits in 25 bits
    localparam int ACC_W = 25;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        chan_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // Per-channel frame means plus the largest of the three
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
        chan_t largest;
    } means_t;

    // One output beat per pixel
    typedef struct packed {
        addr_t addr;
        logic  skin;
    } mask_beat_t;

    // Skin windows in the CbCr plane, both bounds inclusive
    localparam chan_t CB_MIN = 8'd90;
    localparam chan_t CB_MAX = 8'd120;
    localparam chan_t CR_MIN = 8'd139;
    localparam chan_t CR_MAX = 8'd170;

    // Added to both chroma sums after the shift
    localparam chan_t CHROMA_OFFSET = 8'd128;

endpackage

// File: hdl/frame_sequencer.sv
// Pass control for the segmenter. Pass 1 reads the whole frame for the channel
// sums, pass 2 reads it again for classification under credit flow control.
// Also lines up valid and address with the one-cycle memory latency.
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int IMG_W   = 320,
    parameter int IMG_H   = 240,
    parameter int CREDITS = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    output logic            done,
    output logic            rd_en,
    output skin_pkg::addr_t rd_addr,
    output logic            acc_en,
    output logic            mean_go,
    output logic            pix_valid,
    output skin_pkg::addr_t pix_addr,
    input  logic            beat_valid,
    input  logic            credit_return
);

    localparam int CRED_W = $clog2(CREDITS + 1);
    localparam skin_pkg::addr_t LAST_ADDR = skin_pkg::addr_t'(IMG_W * IMG_H - 1);
    localparam skin_pkg::addr_t FRAME_END = skin_pkg::addr_t'(IMG_W * IMG_H);
    localparam logic [CRED_W-1:0] CRED_FULL = CRED_W'(CREDITS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ACCUM,
        S_MEANS,
        S_SCALE,
        S_FINISH
    } state_t;

    state_t            state;
    logic [1:0]        wait_cnt;    // Cycles spent in S_MEANS
    logic [CRED_W-1:0] credits;
    skin_pkg::addr_t   beat_cnt;
    logic              rd_en_d;
    logic              pass2_d;
    logic              take_credit;

    // Pass 1 reads every cycle, pass 2 only while a credit is held
    always_comb begin
        case (state)
            S_ACCUM: rd_en = 1'b1;
            S_SCALE: rd_en = (rd_addr != FRAME_END) && (credits != '0);
            default: rd_en = 1'b0;
        endcase
    end

    assign take_credit = rd_en && (state == S_SCALE);
    assign mean_go     = (state == S_MEANS) && (wait_cnt == 2'd1);  // Last sum has landed
    assign acc_en      = rd_en_d && !pass2_d;
    assign pix_valid   = rd_en_d && pass2_d;

    // Read data shows up one cycle after rd_en
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_en_d <= 1'b0;
            pass2_d <= 1'b0;
        end else begin
            rd_en_d <= rd_en;
            pass2_d <= (state == S_SCALE);
        end
    end

    always_ff @(posedge clk) begin
        pix_addr <= rd_addr;
    end

    // Credits are never reloaded, late returns from the last frame still count
    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CRED_FULL;
        end else begin
            case ({take_credit, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= S_IDLE;
            done     <= 1'b0;
            rd_addr  <= '0;
            wait_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start && !done) begin
                        rd_addr <= '0;
                        state   <= S_ACCUM;
                    end
                end
                S_ACCUM: begin
                    if (rd_addr == LAST_ADDR) begin
                        rd_addr  <= '0;
                        wait_cnt <= '0;
                        state    <= S_MEANS;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                S_MEANS: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == 2'd2) begin  // Largest mean valid next cycle
                        beat_cnt <= '0;
                        state    <= S_SCALE;
                    end
                end
                S_SCALE: begin
                    if (rd_en) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    if (beat_valid) begin
                        if (beat_cnt == LAST_ADDR) begin
                            done  <= 1'b1;
                            state <= S_FINISH;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                S_FINISH: begin
                    // Hold done until start is released
                    if (!start) begin
                        done  <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/channel_mean.sv
// Frame statistics for illumination compensation. Sums each channel during
// pass 1, divides by the pixel count on mean_go, then picks the largest mean.
`timescale 1ns/1ps

module channel_mean #(
    parameter int IMG_W = 320,
    parameter int IMG_H = 240
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              acc_en,
    input  logic              mean_go,
    input  skin_pkg::rgb_t    pixel,
    output skin_pkg::means_t  means
);

    localparam logic [skin_pkg::ACC_W-1:0] PIXELS = skin_pkg::ACC_W'(IMG_W * IMG_H);

    logic [skin_pkg::ACC_W-1:0] sum_r;
    logic [skin_pkg::ACC_W-1:0] sum_g;
    logic [skin_pkg::ACC_W-1:0] sum_b;

    function automatic skin_pkg::chan_t mean_of(input logic [skin_pkg::ACC_W-1:0] sum);
        logic [skin_pkg::ACC_W-1:0] quot;
        quot = sum / PIXELS;  // Truncating
        return quot[7:0];
    endfunction

    // Plain maximum, ties make no difference to the value
    function automatic skin_pkg::chan_t max3(
        input skin_pkg::chan_t a,
        input skin_pkg::chan_t b,
        input skin_pkg::chan_t c
    );
        skin_pkg::chan_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            sum_r <= '0;
            sum_g <= '0;
            sum_b <= '0;
        end else if (mean_go) begin
            // Sums are consumed this cycle, start clean for the next frame
            sum_r <= '0;
            sum_g <= '0;
            sum_b <= '0;
        end else if (acc_en) begin
            sum_r <= sum_r + skin_pkg::ACC_W'(pixel.red);
            sum_g <= sum_g + skin_pkg::ACC_W'(pixel.green);
            sum_b <= sum_b + skin_pkg::ACC_W'(pixel.blue);
        end
    end

    always_ff @(posedge clk) begin
        if (mean_go) begin
            means.red   <= mean_of(sum_r);
            means.green <= mean_of(sum_g);
            means.blue  <= mean_of(sum_b);
        end
        means.largest <= max3(means.red, means.green, means.blue);  // One cycle behind
    end

endmodule

// File: hdl/illum_compensator.sv
// Illumination compensation stage of pass 2. Scales each channel by its frame
// mean over the largest mean, one registered cycle, valid and address alongside.
`timescale 1ns/1ps

module illum_compensator (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  skin_pkg::addr_t  in_addr,
    input  skin_pkg::rgb_t   pixel,
    input  skin_pkg::means_t means,
    output logic             out_valid,
    output skin_pkg::addr_t  out_addr,
    output skin_pkg::rgb_t   comp
);

    function automatic skin_pkg::chan_t scale_chan(
        input skin_pkg::chan_t pix,
        input skin_pkg::chan_t mean,
        input skin_pkg::chan_t largest
    );
        logic [15:0] prod;
        logic [15:0] quot;
        prod = {8'd0, pix} * {8'd0, mean};
        if (largest == 8'd0) begin
            quot = '0;  // Black frame, nothing to scale
        end else begin
            quot = prod / {8'd0, largest};
        end
        return quot[7:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_addr   <= in_addr;
        comp.red   <= scale_chan(pixel.red, means.red, means.largest);
        comp.green <= scale_chan(pixel.green, means.green, means.largest);
        comp.blue  <= scale_chan(pixel.blue, means.blue, means.largest);
    end

endmodule

// File: hdl/ycc_skin_classifier.sv
// Last pass 2 stage. Converts the compensated pixel to Cb and Cr and flags
// skin when both land inside the fixed windows. Output is registered.
`timescale 1ns/1ps

module ycc_skin_classifier (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  skin_pkg::addr_t      in_addr,
    input  skin_pkg::rgb_t       comp,
    output logic                 out_valid,
    output skin_pkg::mask_beat_t beat
);

    logic signed [17:0] r_s;
    logic signed [17:0] g_s;
    logic signed [17:0] b_s;
    logic signed [17:0] cb_sum;
    logic signed [17:0] cr_sum;
    logic signed [17:0] cb_sh;
    logic signed [17:0] cr_sh;
    skin_pkg::chan_t    cb;
    skin_pkg::chan_t    cr;
    logic               skin;

    assign r_s = signed'({10'd0, comp.red});
    assign g_s = signed'({10'd0, comp.green});
    assign b_s = signed'({10'd0, comp.blue});

    // Chroma terms, worst case is about +-28560
    assign cb_sum = 18'sd112 * b_s - 18'sd38 * r_s - 18'sd74 * g_s;
    assign cr_sum = 18'sd112 * r_s - 18'sd94 * g_s - 18'sd18 * b_s;
    assign cb_sh  = cb_sum >>> 8;
    assign cr_sh  = cr_sum >>> 8;

    assign cb = skin_pkg::CHROMA_OFFSET + cb_sh[7:0];  // Wraps to 8 bits
    assign cr = skin_pkg::CHROMA_OFFSET + cr_sh[7:0];

    assign skin = (cb >= skin_pkg::CB_MIN) && (cb <= skin_pkg::CB_MAX) &&
                  (cr >= skin_pkg::CR_MIN) && (cr <= skin_pkg::CR_MAX);

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        beat.addr <= in_addr;
        beat.skin <= skin;
    end

endmodule

// File: hdl/skin_segmenter.sv
// Skin segmentation engine, top level. Two passes over an external frame
// memory, then one mask beat per pixel to a credit-controlled sink.
// Frame size and credit count are set here and passed down.
`timescale 1ns/1ps

module skin_segmenter #(
    parameter int IMG_W   = 320,
    parameter int IMG_H   = 240,
    parameter int CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 done,
    output logic                 rd_en,
    output skin_pkg::addr_t      rd_addr,
    input  skin_pkg::rgb_t       rd_pixel,
    output logic                 out_valid,
    output skin_pkg::mask_beat_t out_beat,
    input  logic                 credit_return
);

    logic             acc_en;
    logic             mean_go;
    logic             pix_valid;
    skin_pkg::addr_t  pix_addr;
    skin_pkg::means_t means;
    logic             comp_valid;
    skin_pkg::addr_t  comp_addr;
    skin_pkg::rgb_t   comp_pixel;

    frame_sequencer #(
        .IMG_W   (IMG_W),
        .IMG_H   (IMG_H),
        .CREDITS (CREDITS)
    ) u_frame_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .done          (done),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .acc_en        (acc_en),
        .mean_go       (mean_go),
        .pix_valid     (pix_valid),
        .pix_addr      (pix_addr),
        .beat_valid    (out_valid),  // Counts beats leaving the engine
        .credit_return (credit_return)
    );

    channel_mean #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_channel_mean (
        .clk     (clk),
        .rst     (rst),
        .acc_en  (acc_en),
        .mean_go (mean_go),
        .pixel   (rd_pixel),
        .means   (means)
    );

    illum_compensator u_illum_compensator (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pix_valid),
        .in_addr   (pix_addr),
        .pixel     (rd_pixel),
        .means     (means),
        .out_valid (comp_valid),
        .out_addr  (comp_addr),
        .comp      (comp_pixel)
    );

    ycc_skin_classifier u_ycc_skin_classifier (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (comp_valid),
        .in_addr   (comp_addr),
        .comp      (comp_pixel),
        .out_valid (out_valid),
        .beat      (out_beat)
    );

endmodule

// File: tests/tb_skin_segmenter.sv
// Testbench for the skin segmenter. Models the frame memory and a credit-returning
// sink, computes the expected mask from its own reference model and checks
// every output beat. Runs a random frame, an all-black frame and another random frame.
`timescale 1ns/1ps

module tb_skin_segmenter;

    localparam int IMG_W   = 16;
    localparam int IMG_H   = 8;
    localparam int CREDITS = 3;
    localparam int NPIX    = IMG_W * IMG_H;
    localparam int MAX_BEATS = 512;

    logic                 clk = 1'b0;
    logic                 rst = 1'b0;
    logic                 start = 1'b0;
    logic                 done;
    logic                 rd_en;
    skin_pkg::addr_t      rd_addr;
    skin_pkg::rgb_t       rd_pixel = '0;
    logic                 out_valid;
    skin_pkg::mask_beat_t out_beat;
    logic                 credit_return = 1'b0;

    skin_pkg::rgb_t mem [NPIX];
    logic           exp_skin [NPIX];
    int             credit_delay [MAX_BEATS];
    int             due_at [MAX_BEATS];
    logic [15:0]    lfsr;
    int beats_seen = 0;
    int ret_idx    = 0;     // Beats already credited back
    int frame_base = 0;
    int reads_seen = 0;
    int read_base  = 0;     // Reads issued before this frame
    int frame_no   = 0;
    int cyc        = 0;
    int stall_from = -1000;
    int skin_seen  = 0;

    skin_segmenter #(
        .IMG_W   (IMG_W),
        .IMG_H   (IMG_H),
        .CREDITS (CREDITS)
    ) u_skin_segmenter (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .done          (done),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_pixel      (rd_pixel),
        .out_valid     (out_valid),
        .out_beat      (out_beat),
        .credit_return (credit_return)
    );

    always #20 clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [23:0] take_bits(input int n);
        logic [23:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[22:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic skin_pkg::rgb_t skin_tone(input logic [1:0] sel);
        case (sel)
            2'd0:    return {8'd200, 8'd140, 8'd110};
            2'd1:    return {8'd220, 8'd160, 8'd130};
            2'd2:    return {8'd180, 8'd120, 8'd100};
            default: return {8'd210, 8'd150, 8'd120};
        endcase
    endfunction

    function automatic int scale_ref(input int p, input int mean, input int largest);
        if (largest == 0) begin
            return 0;
        end
        return (p * mean / largest) & 255;
    endfunction

    function automatic skin_pkg::means_t ref_means();
        int sr;
        int sg;
        int sb;
        skin_pkg::means_t m;
        sr = 0;
        sg = 0;
        sb = 0;
        for (int i = 0; i < NPIX; i++) begin
            sr += mem[i].red;
            sg += mem[i].green;
            sb += mem[i].blue;
        end
        m.red     = 8'(sr / NPIX);
        m.green   = 8'(sg / NPIX);
        m.blue    = 8'(sb / NPIX);
        m.largest = (m.red > m.green) ? m.red : m.green;
        if (m.blue > m.largest) m.largest = m.blue;
        return m;
    endfunction

    function automatic logic ref_skin(input skin_pkg::rgb_t p, input skin_pkg::means_t m);
        int r;
        int g;
        int b;
        int cb;
        int cr;
        r  = scale_ref(p.red, m.red, m.largest);
        g  = scale_ref(p.green, m.green, m.largest);
        b  = scale_ref(p.blue, m.blue, m.largest);
        cb = (128 + ((112 * b - 38 * r - 74 * g) >>> 8)) & 255;
        cr = (128 + ((112 * r - 94 * g - 18 * b) >>> 8)) & 255;
        return (cb >= int'(skin_pkg::CB_MIN)) && (cb <= int'(skin_pkg::CB_MAX)) &&
               (cr >= int'(skin_pkg::CR_MIN)) && (cr <= int'(skin_pkg::CR_MAX));
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // Memory answers each read one cycle later
    always begin
        logic            en;
        skin_pkg::addr_t a;
        @(negedge clk);
        en = rd_en;
        a  = rd_addr;
        @(posedge clk);
        #1;
        if (en) rd_pixel = mem[a];
    end

    // Sink returns one credit per beat once its delay has passed
    always @(posedge clk) begin
        #1;
        cyc = cyc + 1;
        credit_return = 1'b0;
        if (ret_idx < beats_seen && due_at[ret_idx] <= cyc &&
            !(cyc >= stall_from && cyc < stall_from + 40)) begin
            credit_return = 1'b1;
            ret_idx = ret_idx + 1;
        end
    end

    always @(negedge clk) begin
        int pix;
        int due;
        if (!rst) begin
            assert (!done && !rd_en && !out_valid)
            else fail_now("done, rd_en or out_valid was high during reset");
        end
        if (rd_en) begin
            // Two raster passes per frame
            assert (reads_seen - read_base < 2 * NPIX)
            else fail_now("more reads than two passes over the frame");
            assert (rd_addr == skin_pkg::addr_t'((reads_seen - read_base) % NPIX))
            else fail_now($sformatf("Fail at %0t: rd_addr got %0d expected %0d",
                                    $time, rd_addr, (reads_seen - read_base) % NPIX));
            reads_seen = reads_seen + 1;
        end
        if (out_valid) begin
            pix = beats_seen - frame_base;
            assert (pix < NPIX) else fail_now("beat seen after the frame was complete");
            assert (out_beat.addr == skin_pkg::addr_t'(pix))
            else fail_now($sformatf("Fail at %0t: out_beat.addr got %0d expected %0d",
                                    $time, out_beat.addr, pix));
            assert (out_beat.skin == exp_skin[pix])
            else fail_now($sformatf("Fail at %0t: out_beat.skin got %0b expected %0b",
                                    $time, out_beat.skin, exp_skin[pix]));
            if (out_beat.skin) skin_seen++;
            due = cyc + credit_delay[beats_seen];
            if (beats_seen > 0 && due <= due_at[beats_seen-1]) due = due_at[beats_seen-1] + 1;
            due_at[beats_seen] = due;
            if (frame_no == 1 && pix == 20) stall_from = cyc;  // 40 cycles without credits
            beats_seen = beats_seen + 1;
        end
        assert (beats_seen - ret_idx <= CREDITS)
        else fail_now("more beats in flight than credits allow");
        if (done) begin
            assert (beats_seen - frame_base == NPIX)
            else fail_now("done was high before the last beat of the frame");
        end
    end

    task automatic fill_frame(input bit black);
        for (int i = 0; i < NPIX; i++) begin
            if (black) begin
                mem[i] = '0;
            end else begin
                mem[i] = take_bits(24);
                if (take_bits(2) == 0) mem[i] = skin_tone(2'(take_bits(2)));  // About a quarter
            end
        end
    endtask

    task automatic run_frame(input bit black);
        skin_pkg::means_t m;
        int n;
        fill_frame(black);
        m = ref_means();
        for (int i = 0; i < NPIX; i++) exp_skin[i] = ref_skin(mem[i], m);
        frame_no   = frame_no + 1;
        frame_base = beats_seen;
        read_base  = reads_seen;
        @(posedge clk);
        #1 start = 1'b1;
        n = 0;
        while (!done) begin
            @(negedge clk);
            n++;
            if (n > 20000) fail_now("timeout waiting for done");
        end
        repeat (4) begin
            @(negedge clk);
            assert (done) else fail_now("done dropped while start was still high");
        end
        @(posedge clk);
        #1 start = 1'b0;
        @(negedge clk);
        @(negedge clk);
        assert (!done) else fail_now("done did not clear after start went low");
        n = 0;
        while (ret_idx != beats_seen) begin
            @(negedge clk);
            n++;
            if (n > 100) fail_now("timeout waiting for the sink to return all credits");
        end
    endtask

    initial begin
        lfsr = 16'd9335;
        for (int i = 0; i < MAX_BEATS; i++) credit_delay[i] = int'(take_bits(3)) % 7;
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!done && !rd_en && !out_valid)
            else fail_now("done, rd_en or out_valid was high after reset");
        end
        run_frame(1'b0);
        run_frame(1'b1);    // All black, largest mean is zero
        run_frame(1'b0);
        assert (skin_seen > 0) else fail_now("no pixel was classified as skin in any frame");
        $display("Frames checked: %0d, skin pixels seen: %0d", frame_no, skin_seen);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: all.f
hdl/skin_pkg.sv
hdl/frame_sequencer.sv
hdl/channel_mean.sv
hdl/illum_compensator.sv
hdl/ycc_skin_classifier.sv
hdl/skin_segmenter.sv
tests/tb_skin_segmenter.sv

// File: Makefile
# Verilator flow for the skin segmenter testbench

TOP = tb_skin_segmenter

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
